// File: debug_pkg.sv
`default_nettype none

package debug_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word, seen as bytes while loading and as fields afterwards
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic [5:0]  opcode;  // top six bits
        logic [25:0] rest;
    } instr_fields_t;

    typedef union packed
    {
        logic [3:0][7:0] bytes;   // bytes[0] is the first byte received
        instr_fields_t   fields;
    } instr_word_t;

    localparam logic [5:0] end_opcode = 6'b11_1111;  // marks the last program word

    ////////////////////////////////////////////////////////////////////////////
    // command bytes from the host
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] cmd_start      = 8'd1;
    localparam logic [7:0] cmd_continuous = 8'd2;
    localparam logic [7:0] cmd_step_mode  = 8'd3;
    localparam logic [7:0] cmd_reprogram  = 8'd5;
    localparam logic [7:0] cmd_step       = 8'd6;

    // control FSM states
    typedef enum logic [2:0]
    {
        idle,
        programming,
        waiting,
        step_mode,
        continuous,
        sending
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rx_byte_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rx_byte_decode
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       rx_done_tick,
    input  wire logic [7:0] rx_data,
    output logic            byte_valid,
    output logic [7:0]      byte_data,
    output logic            is_start,
    output logic            is_continuous,
    output logic            is_step_mode,
    output logic            is_reprogram,
    output logic            is_step
);
    import debug_pkg::*;

    logic rx_prev;  // receive tick, one cycle late
    logic rx_edge;

    // the uart holds the tick for several cycles, only the rise counts
    assign rx_edge = rx_done_tick & ~rx_prev;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_prev       <= 1'b0;
            byte_valid    <= 1'b0;
            byte_data     <= 8'h00;
            is_start      <= 1'b0;
            is_continuous <= 1'b0;
            is_step_mode  <= 1'b0;
            is_reprogram  <= 1'b0;
            is_step       <= 1'b0;
        end
        else
        begin
            rx_prev    <= rx_done_tick;
            byte_valid <= rx_edge;
            if (rx_edge)
                byte_data <= rx_data;  // held until the next byte

            // classify once here, flags line up with byte_valid
            is_start      <= rx_edge && (rx_data == cmd_start);
            is_continuous <= rx_edge && (rx_data == cmd_continuous);
            is_step_mode  <= rx_edge && (rx_data == cmd_step_mode);
            is_reprogram  <= rx_edge && (rx_data == cmd_reprogram);
            is_step       <= rx_edge && (rx_data == cmd_step);
        end
    end

endmodule

`default_nettype wire

// File: instr_loader.sv
`timescale 1ns/10ps
`default_nettype none

module instr_loader
#(
    parameter int addr_width = 8
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  load_en,
    input  wire logic                  byte_valid,
    input  wire logic [7:0]            byte_data,
    output logic [addr_width-1:0]      mem_addr,
    output debug_pkg::instr_word_t     mem_word,
    output logic                       mem_wr,
    output logic                       load_done
);
    import debug_pkg::*;

    logic [1:0] byte_cnt;  // position of the next byte in the word

    ////////////////////////////////////////////////////////////////////////////
    // word assembly, least significant byte first
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            byte_cnt <= 2'd0;
            mem_addr <= '0;
            mem_word <= '0;
            mem_wr   <= 1'b0;
        end
        else
        begin
            mem_wr <= 1'b0;  // single cycle strobe
            if (!load_en)
            begin
                // next load starts again at word zero
                byte_cnt <= 2'd0;
                mem_addr <= '0;
            end
            else
            begin
                if (mem_wr)
                    mem_addr <= mem_addr + 1'b1;  // advance once the write is done
                if (byte_valid)
                begin
                    mem_word.bytes[byte_cnt] <= byte_data;
                    byte_cnt                 <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3)
                        mem_wr <= 1'b1;  // word complete next cycle
                end
            end
        end
    end

    // end word is detected while it is being written
    assign load_done = mem_wr && (mem_word.fields.opcode == end_opcode);

endmodule

`default_nettype wire

// File: status_sender.sv
`timescale 1ns/10ps
`default_nettype none

module status_sender
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       send_req,
    input  wire logic [7:0] pc_byte,
    input  wire logic       tx_done_tick,
    output logic            tx_start,
    output logic [7:0]      data_out,
    output logic            send_done
);

    logic tx_prev;  // transmit done, one cycle late
    logic tx_edge;

    assign tx_edge = tx_done_tick & ~tx_prev;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_prev   <= 1'b0;
            tx_start  <= 1'b0;
            data_out  <= 8'h00;
            send_done <= 1'b0;
        end
        else
        begin
            tx_prev   <= tx_done_tick;
            send_done <= 1'b0;

            if (send_req)
            begin
                data_out <= pc_byte;  // stays put for the whole transfer
                tx_start <= 1'b1;
            end
            else if (tx_start && tx_edge)
            begin
                // uart finished, release and tell the FSM
                tx_start  <= 1'b0;
                send_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: debug_control.sv
`timescale 1ns/10ps
`default_nettype none

module debug_control
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic halt,
    input  wire logic byte_valid,
    input  wire logic is_start,
    input  wire logic is_continuous,
    input  wire logic is_step_mode,
    input  wire logic is_reprogram,
    input  wire logic is_step,
    input  wire logic load_done,
    input  wire logic send_done,
    output logic      load_en,
    output logic      send_req,
    output logic      cpu_clk_en,
    output logic      debug
);
    import debug_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        req_issued;  // one status byte per visit to sending
    logic        step_hit;

    assign step_hit = (state == step_mode) && byte_valid && is_step;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            idle:
                if (byte_valid && is_start)
                    state_next = programming;  // everything else ignored
            programming:
                if (load_done)
                    state_next = waiting;
            waiting:
                if (byte_valid)
                begin
                    if (is_continuous)
                        state_next = continuous;
                    else if (is_step_mode)
                        state_next = step_mode;
                    else if (is_reprogram)
                        state_next = idle;
                    else
                        state_next = idle;  // unknown byte also restarts
                end
            step_mode:
                if (step_hit)
                    state_next = sending;
            continuous:
                if (halt)
                    state_next = sending;
            sending:
                if (send_done)
                    state_next = halt ? waiting : step_mode;
            default:
                state_next = idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= idle;
            cpu_clk_en <= 1'b0;
            send_req   <= 1'b0;
            req_issued <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // free running in continuous, one pulse per step
            cpu_clk_en <= (state_next == continuous) || step_hit;

            // request goes out after the step clock has passed
            send_req <= (state == sending) && !req_issued;
            if (state != sending)
                req_issued <= 1'b0;
            else
                req_issued <= 1'b1;
        end
    end

    assign load_en = (state == programming);
    assign debug   = (state == programming);  // program memory being written

endmodule

`default_nettype wire

// File: debug_unit.sv
`timescale 1ns/10ps
`default_nettype none

module debug_unit
#(
    parameter int addr_width = 8
)
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              rx_done_tick,
    input  wire logic [7:0]        rx_data,
    input  wire logic              tx_done_tick,
    input  wire logic              halt,
    input  wire logic [7:0]        pc_byte,
    output logic                   tx_start,
    output logic [7:0]             data_out,
    output logic                   cpu_clk_en,
    output logic                   debug,
    output logic [addr_width-1:0]  mem_addr,
    output debug_pkg::instr_word_t mem_word,
    output logic                   mem_wr
);

    // decoded receive side
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       is_start;
    logic       is_continuous;
    logic       is_step_mode;
    logic       is_reprogram;
    logic       is_step;

    // control handshakes
    logic load_en;
    logic load_done;
    logic send_req;
    logic send_done;

    rx_byte_decode i_rx_byte_decode
    (
        .clk           (clk),
        .reset         (reset),
        .rx_done_tick  (rx_done_tick),
        .rx_data       (rx_data),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .is_start      (is_start),
        .is_continuous (is_continuous),
        .is_step_mode  (is_step_mode),
        .is_reprogram  (is_reprogram),
        .is_step       (is_step)
    );

    instr_loader #(.addr_width(addr_width)) i_instr_loader
    (
        .clk        (clk),
        .reset      (reset),
        .load_en    (load_en),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .mem_addr   (mem_addr),
        .mem_word   (mem_word),
        .mem_wr     (mem_wr),
        .load_done  (load_done)
    );

    status_sender i_status_sender
    (
        .clk          (clk),
        .reset        (reset),
        .send_req     (send_req),
        .pc_byte      (pc_byte),
        .tx_done_tick (tx_done_tick),
        .tx_start     (tx_start),
        .data_out     (data_out),
        .send_done    (send_done)
    );

    debug_control i_debug_control
    (
        .clk           (clk),
        .reset         (reset),
        .halt          (halt),
        .byte_valid    (byte_valid),
        .is_start      (is_start),
        .is_continuous (is_continuous),
        .is_step_mode  (is_step_mode),
        .is_reprogram  (is_reprogram),
        .is_step       (is_step),
        .load_done     (load_done),
        .send_done     (send_done),
        .load_en       (load_en),
        .send_req      (send_req),
        .cpu_clk_en    (cpu_clk_en),
        .debug         (debug)
    );

endmodule

`default_nettype wire

// File: debug_unit_assert.sv
`timescale 1ns/10ps
`default_nettype none

module debug_unit_assert
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic mem_wr,
    input  wire logic debug,
    input  wire logic cpu_clk_en,
    input  wire logic tx_start
);

    int assert_errors = 0;  // failures seen so far

    wr_single_cycle: assert property (@(posedge clk) disable iff (reset) mem_wr |=> !mem_wr)
    else
    begin
        $error("mem_wr high for two cycles in a row");
        assert_errors++;
    end

    // memory is only written while the processor is held in debug
    wr_in_debug: assert property (@(posedge clk) disable iff (reset) mem_wr |-> debug)
    else
    begin
        $error("mem_wr high while debug is low");
        assert_errors++;
    end

    clk_not_sending: assert property (@(posedge clk) disable iff (reset)
        !(cpu_clk_en && tx_start))
    else
    begin
        $error("cpu_clk_en and tx_start high together");
        assert_errors++;
    end

endmodule

bind debug_unit debug_unit_assert i_debug_unit_assert
(
    .clk        (clk),
    .reset      (reset),
    .mem_wr     (mem_wr),
    .debug      (debug),
    .cpu_clk_en (cpu_clk_en),
    .tx_start   (tx_start)
);

`default_nettype wire

// File: tb_debug_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_debug_unit;
    import debug_pkg::*;

    typedef enum logic [3:0]
    {
        act_rx,    // receive one byte
        act_word,  // receive a program word with data 1 on the end word
        act_pc,    // set pc_byte
        act_halt,  // set halt
        act_tx,    // wait for a transmission, expect data
        act_clk,   // expect data clock enable cycles since the last check and no transmission
        act_run,   // expect clock enable running
        act_dbg    // expect debug == data with no write pending
    } action_t;

    typedef struct packed
    {
        action_t    act;
        logic [7:0] data;
        logic [7:0] addr;  // expected write address for word rows
    } row_t;

    logic clk;
    logic reset;
    logic rx_done_tick;
    logic [7:0] rx_data;
    logic tx_done_tick;
    logic halt;
    logic [7:0] pc_byte;
    logic tx_start;
    logic [7:0] data_out;
    logic cpu_clk_en;
    logic debug;
    logic [7:0] mem_addr;
    instr_word_t mem_word;
    logic mem_wr;

    row_t        rows[$];
    logic [39:0] exp_writes[$];  // {address, word}
    logic [7:0]  tx_bytes[$];
    logic [31:0] lfsr = 32'h5945_9556;
    logic        table_ready = 1'b0;
    int          clk_en_total = 0;
    int          clk_mark = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    debug_unit #(.addr_width(8)) i_debug_unit
    (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data      (rx_data),
        .tx_done_tick (tx_done_tick),
        .halt         (halt),
        .pc_byte      (pc_byte),
        .tx_start     (tx_start),
        .data_out     (data_out),
        .cpu_clk_en   (cpu_clk_en),
        .debug        (debug),
        .mem_addr     (mem_addr),
        .mem_word     (mem_word),
        .mem_wr       (mem_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic void add_row(input action_t a, input logic [7:0] d,
                                    input logic [7:0] ad = 8'd0);
        rows.push_back({a, d, ad});
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // uart model
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_rx_byte(input logic [7:0] b);
        rx_data      = b;
        rx_done_tick = 1'b1;
        repeat (3) @(negedge clk);
        rx_done_tick = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic send_word(input logic [7:0] addr, input logic last);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};  // one step per bit
        end
        if (last)
            w[31:26] = end_opcode;
        else if (w[31:26] == end_opcode)
            w[31] = 1'b0;  // keep ordinary words away from the end code
        exp_writes.push_back({addr, w});
        for (int i = 0; i < 4; i++)
            send_rx_byte(w[8*i +: 8]);  // low byte first
    endtask

    // answers each tx_start with a done pulse after 5 cycles
    initial
    begin
        tx_done_tick = 1'b0;
        forever
        begin
            @(negedge clk);
            if (tx_start)
            begin
                repeat (5)
                begin
                    assert (tx_start)
                    else
                    begin
                        $display("ERROR %0t: tx_start dropped before transmit done", $time);
                        protocol_errors++;
                    end
                    @(negedge clk);
                end
                tx_done_tick = 1'b1;
                @(negedge clk);
                tx_done_tick = 1'b0;
                assert (data_out == pc_byte)
                else
                begin
                    $display("ERROR %0t: data_out got %h expected %h", $time, data_out, pc_byte);
                    value_errors++;
                end
                tx_bytes.push_back(data_out);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write monitor and clock enable counter
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_write();
        logic [39:0] exp;
        assert (exp_writes.size() != 0)
        else
        begin
            $display("ERROR %0t: unexpected write at address %0d", $time, mem_addr);
            protocol_errors++;
        end
        if (exp_writes.size() != 0)
        begin
            exp = exp_writes.pop_front();
            assert (mem_addr == exp[39:32])
            else
            begin
                $display("ERROR %0t: mem_addr got %0d expected %0d", $time, mem_addr, exp[39:32]);
                value_errors++;
            end
            assert (mem_word == exp[31:0])
            else
            begin
                $display("ERROR %0t: mem_word got %h expected %h", $time, mem_word, exp[31:0]);
                value_errors++;
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (cpu_clk_en)
                clk_en_total++;
            if (mem_wr)
                check_write();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // idle ignores everything but start
        add_row(act_dbg, 8'd0);
        add_row(act_rx, 8'h07);
        add_row(act_rx, cmd_step);
        add_row(act_dbg, 8'd0);
        // first load
        add_row(act_rx, cmd_start);
        add_row(act_dbg, 8'd1);
        add_row(act_word, 8'd0, 8'd0);
        add_row(act_word, 8'd0, 8'd1);
        add_row(act_word, 8'd1, 8'd2);
        add_row(act_dbg, 8'd0);
        // step mode
        add_row(act_pc, 8'h3c);
        add_row(act_rx, cmd_step_mode);
        add_row(act_clk, 8'd0);
        add_row(act_rx, cmd_step);
        add_row(act_tx, 8'h3c);
        add_row(act_clk, 8'd1);
        add_row(act_rx, 8'h09);  // not a step
        add_row(act_clk, 8'd0);
        add_row(act_halt, 8'd1);  // back to waiting after this step
        add_row(act_pc, 8'h5a);
        add_row(act_rx, cmd_step);
        add_row(act_tx, 8'h5a);
        add_row(act_clk, 8'd1);
        // reprogram then reload from address zero
        add_row(act_rx, cmd_reprogram);
        add_row(act_halt, 8'd0);
        add_row(act_rx, cmd_start);
        add_row(act_dbg, 8'd1);
        add_row(act_word, 8'd0, 8'd0);
        add_row(act_word, 8'd1, 8'd1);
        add_row(act_dbg, 8'd0);
        // continuous until halt
        add_row(act_pc, 8'ha5);
        add_row(act_rx, cmd_continuous);
        add_row(act_run, 8'd0);
        add_row(act_halt, 8'd1);
        add_row(act_tx, 8'ha5);
        add_row(act_clk, 8'd0);
        add_row(act_pc, 8'h66);
        add_row(act_rx, cmd_step_mode);
        add_row(act_rx, cmd_step);
        add_row(act_tx, 8'h66);
        add_row(act_clk, 8'd1);
        // unknown byte in waiting goes back to idle
        add_row(act_rx, 8'h44);
        add_row(act_halt, 8'd0);
        add_row(act_rx, cmd_start);
        add_row(act_dbg, 8'd1);
        add_row(act_word, 8'd1, 8'd0);
        add_row(act_dbg, 8'd0);
    endtask

    task automatic apply_row(input row_t r);
        logic [7:0] got;
        case (r.act)
            act_rx:
                send_rx_byte(r.data);
            act_word:
                send_word(r.addr, r.data[0]);
            act_pc:
                pc_byte = r.data;
            act_halt:
            begin
                halt = r.data[0];
                repeat (2) @(negedge clk);  // let the clock enable settle
                clk_mark = clk_en_total;
            end
            act_tx:
            begin
                // uart model pushes on the falling edge, poll on the rising one
                while (tx_bytes.size() == 0)
                    @(posedge clk);
                @(negedge clk);
                got = tx_bytes.pop_front();
                assert (got == r.data)
                else
                begin
                    $display("ERROR %0t: data_out got %h expected %h", $time, got, r.data);
                    value_errors++;
                end
            end
            act_clk:
            begin
                repeat (8) @(negedge clk);
                assert (clk_en_total - clk_mark == int'(r.data))
                else
                begin
                    $display("ERROR %0t: cpu_clk_en cycles got %0d expected %0d",
                             $time, clk_en_total - clk_mark, r.data);
                    value_errors++;
                end
                assert (tx_bytes.size() == 0 && !tx_start)
                else
                begin
                    $display("ERROR %0t: a transmission happened that was not expected", $time);
                    protocol_errors++;
                end
                clk_mark = clk_en_total;
            end
            act_run:
            begin
                assert (clk_en_total > clk_mark && cpu_clk_en)
                else
                begin
                    $display("ERROR %0t: cpu_clk_en got %b expected 1", $time, cpu_clk_en);
                    value_errors++;
                end
            end
            default:
            begin
                @(negedge clk);
                assert (debug == r.data[0])
                else
                begin
                    $display("ERROR %0t: debug got %b expected %b", $time, debug, r.data[0]);
                    value_errors++;
                end
                assert (exp_writes.size() == 0)
                else
                begin
                    $display("ERROR %0t: %0d expected writes never happened",
                             $time, exp_writes.size());
                    protocol_errors++;
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        reset        = 1'b1;
        rx_done_tick = 1'b0;
        rx_data      = 8'h00;
        halt         = 1'b0;
        pc_byte      = 8'h00;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        assert (!mem_wr && !tx_start && !cpu_clk_en && !debug && mem_addr == 8'd0)
        else
        begin
            $display("ERROR %0t: mem_wr tx_start cpu_clk_en debug got %b%b%b%b expected 0000",
                     $time, mem_wr, tx_start, cpu_clk_en, debug);
            $display("ERROR %0t: mem_addr after reset got %0d expected 0", $time, mem_addr);
            value_errors++;
        end

        foreach (rows[i])
            apply_row(rows[i]);
        repeat (4) @(negedge clk);

        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors,
                 protocol_errors, i_debug_unit.i_debug_unit_assert.assert_errors);
        if (value_errors == 0 && protocol_errors == 0 &&
            i_debug_unit.i_debug_unit_assert.assert_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        wait (table_ready);
        #(rows.size() * 2 * 20 * 40);  // twice rows x 20 cycles x 40 ns
        $display("watchdog expired before the stimulus table finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
debug_pkg.sv
rx_byte_decode.sv
instr_loader.sv
status_sender.sv
debug_control.sv
debug_unit.sv
debug_unit_assert.sv
tb_debug_unit.sv
